/* include/prio_macros.svh */
// priority stage constants
// port count, queue depth and the opcode encodings seen on the hold ports

`ifndef PRIO_MACROS_SVH
`define PRIO_MACROS_SVH

// number of request ports and entries per issue queue
`define PRIO_NUM_PORTS   4
`define PRIO_QUEUE_DEPTH 16

// opcodes, zero means the port is idle this cycle
`define PRIO_CMD_NONE 4'd0
`define PRIO_CMD_ADD  4'd1
`define PRIO_CMD_SUB  4'd2
`define PRIO_CMD_SHL  4'd5
`define PRIO_CMD_SHR  4'd6

`endif

/* hdl/prio_pkg.sv */
// priority stage types
// request, queue entry and invalid report layouts shared by all blocks

package prio_pkg;

   typedef logic [3:0]  cmd_t;
   typedef logic [1:0]  tag_t;
   typedef logic [1:0]  port_id_t;
   typedef logic [31:0] data_t;

   // occupancy needs one bit more than the index to reach a full queue
   typedef logic [4:0]  qcount_t;

   // one port's command as presented by the hold register
   typedef struct packed {
      cmd_t  cmd;
      tag_t  tag;
      data_t data1;
      data_t data2;
   } hold_req_t;

   // port and tag side by side form the 4-bit response tag seen by the units
   typedef struct packed {
      cmd_t     cmd;
      port_id_t port;
      tag_t     tag;
      data_t    data1;
      data_t    data2;
   } queue_entry_t;

   typedef struct packed {
      logic op;
      tag_t tag;
   } invalid_rsp_t;

   // which queue wins the next same-port conflict
   typedef enum logic {
      TURN_ADD   = 1'b0,
      TURN_SHIFT = 1'b1
   } prio_turn_e;

endpackage

/* hdl/cmd_decode.sv */
// command decoder
// steers each port's command to the add or shift queue and flags bad opcodes

`include "prio_macros.svh"

module cmd_decode
   import prio_pkg::*;
(
   input  logic                                  c_clk,
   input  logic                                  rst,
   input  hold_req_t    [`PRIO_NUM_PORTS-1:0]    hold,
   output queue_entry_t [`PRIO_NUM_PORTS-1:0]    entries,
   output logic         [`PRIO_NUM_PORTS-1:0]    add_sel,
   output logic         [`PRIO_NUM_PORTS-1:0]    shift_sel,
   output invalid_rsp_t [`PRIO_NUM_PORTS-1:0]    invalid
);

   logic [`PRIO_NUM_PORTS-1:0] bad_op;
   logic [`PRIO_NUM_PORTS-1:0] inv_op_q;
   tag_t [`PRIO_NUM_PORTS-1:0] inv_tag_q;

   genvar p;

   generate
      for (p = 0; p < `PRIO_NUM_PORTS; p++) begin : g_port

         // the port number is stamped into the entry so the units can route results back
         assign entries[p] = '{
            cmd:   hold[p].cmd,
            port:  port_id_t'(p),
            tag:   hold[p].tag,
            data1: hold[p].data1,
            data2: hold[p].data2
         };

         assign add_sel[p] = (hold[p].cmd == `PRIO_CMD_ADD) ||
                             (hold[p].cmd == `PRIO_CMD_SUB);

         assign shift_sel[p] = (hold[p].cmd == `PRIO_CMD_SHL) ||
                               (hold[p].cmd == `PRIO_CMD_SHR);

         // an idle port is not an error, anything else unknown is
         assign bad_op[p] = (hold[p].cmd != `PRIO_CMD_NONE) &&
                            !add_sel[p] && !shift_sel[p];

         assign invalid[p] = '{op: inv_op_q[p], tag: inv_tag_q[p]};

      end
   endgenerate

   // the report lasts exactly one cycle since the flag reloads every edge
   always_ff @(posedge c_clk) begin
      if (rst) begin
         inv_op_q <= '0;
      end else begin
         inv_op_q <= bad_op;
      end
   end

   always_ff @(posedge c_clk) begin
      for (int i = 0; i < `PRIO_NUM_PORTS; i++) begin
         inv_tag_q[i] <= hold[i].tag;
      end
   end

endmodule

/* hdl/cmd_queue.sv */
// issue queue
// shifting queue that takes up to one entry per port each cycle in port order
// and presents its oldest entry as the head

`include "prio_macros.svh"

module cmd_queue
   import prio_pkg::*;
#(
   parameter int DEPTH = `PRIO_QUEUE_DEPTH
) (
   input  logic                               c_clk,
   input  logic                               rst,
   input  queue_entry_t [`PRIO_NUM_PORTS-1:0] entries,
   input  logic         [`PRIO_NUM_PORTS-1:0] sel,
   input  logic                               pop,
   output queue_entry_t                       head,
   output logic                               head_vld
);

   queue_entry_t mem [DEPTH];

   qcount_t count;
   qcount_t count_next;
   qcount_t fill;
   qcount_t [`PRIO_NUM_PORTS-1:0] slot;

   logic advance;

   assign head     = mem[0];
   assign head_vld = (count != '0);

   // a pop on an empty queue would corrupt the count, so it is ignored here
   assign advance = pop && head_vld;

   // each selected port takes the next free slot, counted from the
   // position the tail will have after this cycle's pop
   always_comb begin
      fill = advance ? count - qcount_t'(1) : count;
      for (int i = 0; i < `PRIO_NUM_PORTS; i++) begin
         slot[i] = fill;
         if (sel[i]) begin
            fill = fill + qcount_t'(1);
         end
      end
      count_next = fill;
   end

   always_ff @(posedge c_clk) begin
      if (rst) begin
         count <= '0;
      end else begin
         count <= count_next;
      end
   end

   // storage moves one place forward on a pop, then new entries land behind
   // whatever remains
   always_ff @(posedge c_clk) begin
      for (int k = 0; k < DEPTH - 1; k++) begin
         if (advance) begin
            mem[k] <= mem[k+1];
         end
      end
      for (int k = 0; k < DEPTH; k++) begin
         for (int i = 0; i < `PRIO_NUM_PORTS; i++) begin
            if (sel[i] && (slot[i] == qcount_t'(k))) begin
               mem[k] <= entries[i];
            end
         end
      end
   end

   // the environment keeps the load low enough that nothing is ever dropped
   a_no_overflow : assert property (
      @(posedge c_clk) disable iff (rst)
      count_next <= qcount_t'(DEPTH)
   ) else $error("cmd_queue overflow, count_next %0d", count_next);

   // the arbiter only pops a head that is actually there
   a_pop_has_head : assert property (
      @(posedge c_clk) disable iff (rst)
      pop |-> head_vld
   ) else $error("cmd_queue pop while empty");

endmodule

/* hdl/port_arbiter.sv */
// port conflict arbiter
// lets both heads issue unless they come from the same port, in which case
// the two queues take turns

module port_arbiter
   import prio_pkg::*;
(
   input  logic         c_clk,
   input  logic         rst,
   input  queue_entry_t add_head,
   input  logic         add_head_vld,
   input  queue_entry_t shift_head,
   input  logic         shift_head_vld,
   output logic         add_pop,
   output logic         shift_pop
);

   prio_turn_e turn;
   logic       conflict;

   assign conflict = add_head_vld && shift_head_vld &&
                     (add_head.port == shift_head.port);

   assign add_pop   = add_head_vld && (!conflict || (turn == TURN_ADD));
   assign shift_pop = shift_head_vld && (!conflict || (turn == TURN_SHIFT));

   // turn only moves when it was actually used
   always_ff @(posedge c_clk) begin
      if (rst) begin
         turn <= TURN_ADD;
      end else if (conflict) begin
         turn <= (turn == TURN_ADD) ? TURN_SHIFT : TURN_ADD;
      end
   end

   a_one_per_port : assert property (
      @(posedge c_clk) disable iff (rst)
      !(add_pop && shift_pop && (add_head.port == shift_head.port))
   ) else $error("port_arbiter issued both units from port %0d", add_head.port);

   // the losing head has to wait in place and come back unchanged
   a_loser_held : assert property (
      @(posedge c_clk) disable iff (rst)
      (conflict && !add_pop) |=> (add_head_vld && $stable(add_head))
   ) else $error("port_arbiter add head lost after conflict");

   a_shift_loser_held : assert property (
      @(posedge c_clk) disable iff (rst)
      (conflict && !shift_pop) |=> (shift_head_vld && $stable(shift_head))
   ) else $error("port_arbiter shift head lost after conflict");

endmodule

/* hdl/prio_top.sv */
// priority stage top level
// decodes the four ports into the add and shift queues and issues their heads
// to the adder and the shifter

`include "prio_macros.svh"

module prio_top
   import prio_pkg::*;
(
   input  logic                                  c_clk,
   input  logic                                  rst,
   input  hold_req_t    [`PRIO_NUM_PORTS-1:0]    hold,
   output logic                                  adder_out_vld,
   output queue_entry_t                          adder_out,
   output logic                                  shift_out_vld,
   output queue_entry_t                          shift_out,
   output invalid_rsp_t [`PRIO_NUM_PORTS-1:0]    invalid
);

   queue_entry_t [`PRIO_NUM_PORTS-1:0] entries;
   logic         [`PRIO_NUM_PORTS-1:0] add_sel;
   logic         [`PRIO_NUM_PORTS-1:0] shift_sel;

   queue_entry_t add_head;
   logic         add_head_vld;
   logic         add_pop;

   queue_entry_t shift_head;
   logic         shift_head_vld;
   logic         shift_pop;

   cmd_decode u_decode (
      .c_clk     (c_clk),
      .rst       (rst),
      .hold      (hold),
      .entries   (entries),
      .add_sel   (add_sel),
      .shift_sel (shift_sel),
      .invalid   (invalid)
   );

   // both queues see every port's entry, the select mask decides which they keep
   cmd_queue #(
      .DEPTH (`PRIO_QUEUE_DEPTH)
   ) u_add_queue (
      .c_clk    (c_clk),
      .rst      (rst),
      .entries  (entries),
      .sel      (add_sel),
      .pop      (add_pop),
      .head     (add_head),
      .head_vld (add_head_vld)
   );

   cmd_queue #(
      .DEPTH (`PRIO_QUEUE_DEPTH)
   ) u_shift_queue (
      .c_clk    (c_clk),
      .rst      (rst),
      .entries  (entries),
      .sel      (shift_sel),
      .pop      (shift_pop),
      .head     (shift_head),
      .head_vld (shift_head_vld)
   );

   port_arbiter u_arbiter (
      .c_clk          (c_clk),
      .rst            (rst),
      .add_head       (add_head),
      .add_head_vld   (add_head_vld),
      .shift_head     (shift_head),
      .shift_head_vld (shift_head_vld),
      .add_pop        (add_pop),
      .shift_pop      (shift_pop)
   );

   // a pop is the issue, so the units see the head in the same cycle it leaves
   assign adder_out_vld = add_pop;
   assign adder_out     = add_head;
   assign shift_out_vld = shift_pop;
   assign shift_out     = shift_head;

endmodule

/* testbench/tb_prio_top.sv */
// testbench for the priority stage
// drives the four ports, models both queues and the conflict turn, and checks
// every issue and every invalid report against that model

`include "prio_macros.svh"

module tb_prio_top
   import prio_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   logic                                 c_clk;
   logic                                 rst;
   hold_req_t    [`PRIO_NUM_PORTS-1:0]   hold;
   logic                                 adder_out_vld;
   queue_entry_t                         adder_out;
   logic                                 shift_out_vld;
   queue_entry_t                         shift_out;
   invalid_rsp_t [`PRIO_NUM_PORTS-1:0]   invalid;

   // reference model state
   queue_entry_t add_model[$];
   queue_entry_t shift_model[$];
   prio_turn_e   turn_model;

   logic         exp_add_vld;
   logic         exp_shift_vld;
   logic         exp_conflict;
   queue_entry_t exp_add_out;
   queue_entry_t exp_shift_out;
   logic [3:0]   exp_inv_op;
   logic [7:0]   exp_inv_tag;
   logic [3:0]   got_inv_op;
   logic [7:0]   got_inv_tag;

   logic   checking = 1'b0;
   int     conflicts_seen = 0;
   int     dual_issues_seen = 0;
   integer seed = 29;

   cmd_t valid_ops [4] = '{`PRIO_CMD_ADD, `PRIO_CMD_SUB, `PRIO_CMD_SHL, `PRIO_CMD_SHR};

   prio_top i_dut (
      .c_clk         (c_clk),
      .rst           (rst),
      .hold          (hold),
      .adder_out_vld (adder_out_vld),
      .adder_out     (adder_out),
      .shift_out_vld (shift_out_vld),
      .shift_out     (shift_out),
      .invalid       (invalid)
   );

   initial begin
      c_clk = 1'b0;
      forever #10 c_clk = ~c_clk;
   end

   function automatic logic is_add_op(input cmd_t c);
      return (c == `PRIO_CMD_ADD) || (c == `PRIO_CMD_SUB);
   endfunction

   function automatic logic is_shift_op(input cmd_t c);
      return (c == `PRIO_CMD_SHL) || (c == `PRIO_CMD_SHR);
   endfunction

   function automatic hold_req_t make_req(input cmd_t c, input tag_t t,
                                          input data_t d1, input data_t d2);
      return '{cmd: c, tag: t, data1: d1, data2: d2};
   endfunction

   // random opcode mix with idle slots and a few illegal encodings
   function automatic cmd_t pick_cmd(input logic [3:0] r);
      case (r)
         4'd3, 4'd4, 4'd5: return `PRIO_CMD_ADD;
         4'd6, 4'd7:       return `PRIO_CMD_SUB;
         4'd8, 4'd9:       return `PRIO_CMD_SHL;
         4'd10, 4'd11:     return `PRIO_CMD_SHR;
         4'd12:            return 4'd3;
         4'd13:            return 4'd7;
         4'd14:            return 4'd12;
         default:          return `PRIO_CMD_NONE;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [71:0] exp_val,
                                  input logic [71:0] got_val);
      $display("MISMATCH %s expected %h got %h", name, exp_val, got_val);
      $display("Checks failed");
      $fatal(1, "%s differs from the model", name);
   endtask

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Checks failed");
      $fatal(1, "%s", what);
   endtask

   task automatic drive_ports(input hold_req_t [`PRIO_NUM_PORTS-1:0] reqs);
      @(negedge c_clk);
      hold = reqs;
   endtask

   task automatic wait_drained(input int limit);
      int cycles;
      cycles = 0;
      drive_ports('0);
      while ((add_model.size() != 0) || (shift_model.size() != 0) || (exp_inv_op != '0)) begin
         if (cycles >= limit) begin
            report_failure("queues did not drain before the timeout");
         end else begin
            @(negedge c_clk);
            cycles++;
         end
      end
   endtask

   // only flagged reports carry a meaningful tag
   always_comb begin
      for (int p = 0; p < `PRIO_NUM_PORTS; p++) begin
         got_inv_op[p] = invalid[p].op;
         got_inv_tag[2*p +: 2] = invalid[p].op ? invalid[p].tag : 2'b00;
      end
   end

   // the model samples the ports at each rising edge, exactly like the DUT,
   // and publishes what the DUT has to show until the next edge
   always @(posedge c_clk) begin
      queue_entry_t e;
      queue_entry_t next_add;
      queue_entry_t next_shift;
      logic         add_vld;
      logic         shift_vld;
      logic         clash;
      logic [3:0]   inv_op;
      logic [7:0]   inv_tag;
      checking <= 1'b1;
      if (rst) begin
         add_model.delete();
         shift_model.delete();
         turn_model = TURN_ADD;
         exp_add_vld <= 1'b0;
         exp_shift_vld <= 1'b0;
         exp_conflict <= 1'b0;
         exp_add_out <= '0;
         exp_shift_out <= '0;
         exp_inv_op <= '0;
         exp_inv_tag <= '0;
      end else begin
         if (exp_conflict) begin
            turn_model = (turn_model == TURN_ADD) ? TURN_SHIFT : TURN_ADD;
            conflicts_seen++;
         end
         if (exp_add_vld && exp_shift_vld) begin
            dual_issues_seen++;
         end
         if (exp_add_vld) begin
            void'(add_model.pop_front());
         end
         if (exp_shift_vld) begin
            void'(shift_model.pop_front());
         end
         inv_op = '0;
         inv_tag = '0;
         for (int p = 0; p < `PRIO_NUM_PORTS; p++) begin
            e = '{cmd: hold[p].cmd, port: port_id_t'(p), tag: hold[p].tag,
                  data1: hold[p].data1, data2: hold[p].data2};
            if (is_add_op(hold[p].cmd)) begin
               add_model.push_back(e);
            end else if (is_shift_op(hold[p].cmd)) begin
               shift_model.push_back(e);
            end else if (hold[p].cmd != `PRIO_CMD_NONE) begin
               inv_op[p] = 1'b1;
               inv_tag[2*p +: 2] = hold[p].tag;
            end
         end
         add_vld = (add_model.size() != 0);
         shift_vld = (shift_model.size() != 0);
         next_add = add_vld ? add_model[0] : '0;
         next_shift = shift_vld ? shift_model[0] : '0;
         clash = add_vld && shift_vld && (next_add.port == next_shift.port);
         exp_add_vld <= add_vld && (!clash || (turn_model == TURN_ADD));
         exp_shift_vld <= shift_vld && (!clash || (turn_model == TURN_SHIFT));
         exp_conflict <= clash;
         exp_add_out <= next_add;
         exp_shift_out <= next_shift;
         exp_inv_op <= inv_op;
         exp_inv_tag <= inv_tag;
      end
   end

   a_adder_vld : assert property (
      @(posedge c_clk) checking |-> (adder_out_vld == exp_add_vld)
   ) else report_mismatch("adder_out_vld", 72'($sampled(exp_add_vld)),
                          72'($sampled(adder_out_vld)));

   a_adder_out : assert property (
      @(posedge c_clk) (checking && exp_add_vld) |-> (adder_out == exp_add_out)
   ) else report_mismatch("adder_out", 72'($sampled(exp_add_out)),
                          72'($sampled(adder_out)));

   a_shift_vld : assert property (
      @(posedge c_clk) checking |-> (shift_out_vld == exp_shift_vld)
   ) else report_mismatch("shift_out_vld", 72'($sampled(exp_shift_vld)),
                          72'($sampled(shift_out_vld)));

   a_shift_out : assert property (
      @(posedge c_clk) (checking && exp_shift_vld) |-> (shift_out == exp_shift_out)
   ) else report_mismatch("shift_out", 72'($sampled(exp_shift_out)),
                          72'($sampled(shift_out)));

   a_invalid_op : assert property (
      @(posedge c_clk) checking |-> (got_inv_op == exp_inv_op)
   ) else report_mismatch("invalid.op", 72'($sampled(exp_inv_op)),
                          72'($sampled(got_inv_op)));

   a_invalid_tag : assert property (
      @(posedge c_clk) checking |-> (got_inv_tag == exp_inv_tag)
   ) else report_mismatch("invalid.tag", 72'($sampled(exp_inv_tag)),
                          72'($sampled(got_inv_tag)));

   initial begin
      hold_req_t [`PRIO_NUM_PORTS-1:0] reqs;
      logic        add_room;
      logic        shift_room;
      cmd_t        c;
      logic [31:0] rnd;
      rst = 1'b1;
      hold = '0;
      repeat (10) @(posedge c_clk);
      @(negedge c_clk);
      rst = 1'b0;

      // one command at a time from every port with every legal opcode
      for (int p = 0; p < `PRIO_NUM_PORTS; p++) begin
         for (int k = 0; k < 4; k++) begin
            reqs = '0;
            reqs[p] = make_req(valid_ops[k], tag_t'(k), data_t'(32'hC0DE_0000 + p * 16 + k),
                               data_t'(32'h0BAD_F000 - p * 256 - k));
            drive_ports(reqs);
            wait_drained(20);
         end
      end

      // a full cycle of add work, then two more behind it
      reqs[0] = make_req(`PRIO_CMD_ADD, 2'd0, 32'h0000_0010, 32'h0000_0001);
      reqs[1] = make_req(`PRIO_CMD_SUB, 2'd1, 32'h0000_0020, 32'h0000_0002);
      reqs[2] = make_req(`PRIO_CMD_ADD, 2'd2, 32'h0000_0030, 32'h0000_0003);
      reqs[3] = make_req(`PRIO_CMD_SUB, 2'd3, 32'h0000_0040, 32'h0000_0004);
      drive_ports(reqs);
      reqs = '0;
      reqs[0] = make_req(`PRIO_CMD_ADD, 2'd1, 32'h0000_0050, 32'h0000_0005);
      reqs[3] = make_req(`PRIO_CMD_SUB, 2'd2, 32'h0000_0060, 32'h0000_0006);
      drive_ports(reqs);
      wait_drained(20);

      // illegal opcodes on every port, then mixed with legal ones
      reqs[0] = make_req(4'd3, 2'd1, 32'h1111_1111, 32'h2222_2222);
      reqs[1] = make_req(4'd4, 2'd2, 32'h3333_3333, 32'h4444_4444);
      reqs[2] = make_req(4'd7, 2'd3, 32'h5555_5555, 32'h6666_6666);
      reqs[3] = make_req(4'd15, 2'd0, 32'h7777_7777, 32'h8888_8888);
      drive_ports(reqs);
      reqs = '0;
      reqs[0] = make_req(`PRIO_CMD_ADD, 2'd3, 32'h0000_00A0, 32'h0000_000A);
      reqs[1] = make_req(4'd9, 2'd1, 32'h0000_00B0, 32'h0000_000B);
      reqs[2] = make_req(`PRIO_CMD_SHL, 2'd2, 32'h0000_00C0, 32'h0000_000C);
      drive_ports(reqs);
      wait_drained(20);

      // port 1 ends up at both heads in the same cycle, twice in a row
      for (int n = 0; n < 2; n++) begin
         reqs = '0;
         reqs[0] = make_req(`PRIO_CMD_ADD, 2'd0, 32'h0000_0100, data_t'(n));
         reqs[1] = make_req(`PRIO_CMD_SUB, 2'd1, 32'h0000_0200, data_t'(n));
         drive_ports(reqs);
         reqs = '0;
         reqs[1] = make_req(valid_ops[2 + n], 2'd2, 32'h0000_0300, data_t'(n));
         drive_ports(reqs);
         wait_drained(20);
      end

      // different ports at the heads issue together
      reqs = '0;
      reqs[2] = make_req(`PRIO_CMD_ADD, 2'd1, 32'h0000_0400, 32'h0000_0041);
      reqs[3] = make_req(`PRIO_CMD_SHR, 2'd2, 32'h0000_0500, 32'h0000_0051);
      drive_ports(reqs);
      wait_drained(20);

      // random traffic, held back whenever a queue gets close to full
      for (int n = 0; n < 400; n++) begin
         add_room = (add_model.size() < 7);
         shift_room = (shift_model.size() < 7);
         for (int p = 0; p < `PRIO_NUM_PORTS; p++) begin
            rnd = $random(seed);
            c = pick_cmd(rnd[3:0]);
            if ((is_add_op(c) && !add_room) || (is_shift_op(c) && !shift_room)) begin
               c = `PRIO_CMD_NONE;
            end
            reqs[p] = make_req(c, rnd[5:4], $random(seed), $random(seed));
         end
         drive_ports(reqs);
      end
      wait_drained(100);

      if ((conflicts_seen < 2) || (dual_issues_seen < 1)) begin
         report_failure("stimulus did not produce the expected port conflicts");
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

/* filelist.f */
+incdir+include
hdl/prio_pkg.sv
hdl/cmd_decode.sv
hdl/cmd_queue.sv
hdl/port_arbiter.sv
hdl/prio_top.sv
testbench/tb_prio_top.sv

/* Makefile */
# Verilator build and run for the priority stage testbench
# any variable below can be overridden on the command line, e.g. make sim TOP=...

VERILATOR ?= verilator
TOP       ?= tb_prio_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

.PHONY: sim clean

# the simulator exits non-zero on $fatal, so make reports the failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
